// File: logic/decode_pkg.sv
package decode_pkg;

  // ####################################################################
  // Sizes and fixed encodings
  // ####################################################################

  localparam int LANES = 2; // Instruction words per fetch packet.
  localparam int XLEN = 32;

  localparam logic [6:0] opcode_lui       = 7'b0110111;
  localparam logic [6:0] opcode_immediate = 7'b0010011;
  localparam logic [6:0] opcode_register  = 7'b0110011;
  localparam logic [6:0] opcode_system    = 7'b1110011;
  localparam logic [6:0] opcode_fence     = 7'b0001111;

  localparam logic [2:0] funct_add  = 3'b000;
  localparam logic [2:0] funct_sll  = 3'b001;
  localparam logic [2:0] funct_slt  = 3'b010;
  localparam logic [2:0] funct_sltu = 3'b011;
  localparam logic [2:0] funct_xor  = 3'b100;
  localparam logic [2:0] funct_srl  = 3'b101;
  localparam logic [2:0] funct_or   = 3'b110;
  localparam logic [2:0] funct_and  = 3'b111;

  localparam logic [2:0] funct_mul    = 3'b000;
  localparam logic [2:0] funct_mulh   = 3'b001;
  localparam logic [2:0] funct_mulhsu = 3'b010;
  localparam logic [2:0] funct_mulhu  = 3'b011;
  localparam logic [2:0] funct_div    = 3'b100;
  localparam logic [2:0] funct_divu   = 3'b101;
  localparam logic [2:0] funct_rem    = 3'b110;
  localparam logic [2:0] funct_remu   = 3'b111;

  localparam logic [2:0] funct_priv   = 3'b000; // ECALL, EBREAK, MRET and WFI.
  localparam logic [2:0] funct_csrrw  = 3'b001;
  localparam logic [2:0] funct_csrrs  = 3'b010;
  localparam logic [2:0] funct_csrrc  = 3'b011;
  localparam logic [2:0] funct_csrrwi = 3'b101;
  localparam logic [2:0] funct_csrrsi = 3'b110;
  localparam logic [2:0] funct_csrrci = 3'b111;

  localparam logic [2:0] funct_fence   = 3'b000;
  localparam logic [2:0] funct_fence_i = 3'b001;

  localparam logic [6:0] funct7_base   = 7'b0000000;
  localparam logic [6:0] funct7_alt    = 7'b0100000; // SUB, SRA and SRAI.
  localparam logic [6:0] funct7_muldiv = 7'b0000001;

  localparam logic [11:0] csr_ecall  = 12'h000;
  localparam logic [11:0] csr_ebreak = 12'h001;
  localparam logic [11:0] csr_mret   = 12'h302;
  localparam logic [11:0] csr_wfi    = 12'h105;

  localparam logic [6:0] csr_counter_page = 7'b1100000; // Addresses 0xC00 to 0xC1F.
  localparam logic [1:0] mode_machine = 2'b11;

  localparam logic [XLEN-1:0] nop_instr = 32'h0000_0013; // addi x0, x0, 0

  // ####################################################################
  // Instruction word views
  // ####################################################################

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_view_type;

  typedef struct packed {
    logic [11:0] csr;
    logic [4:0]  src; // rs1 for register forms, zimm for immediate forms.
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } sys_view_type;

  typedef union packed {
    r_view_type   r_view;
    sys_view_type sys_view;
  } instr_word_u;

  // ####################################################################
  // Decoded operation flags
  // ####################################################################

  typedef struct packed {
    logic alu_add;
    logic alu_sub;
    logic alu_sll;
    logic alu_srl;
    logic alu_sra;
    logic alu_slt;
    logic alu_sltu;
    logic alu_and;
    logic alu_or;
    logic alu_xor;
  } alu_op_type;

  typedef struct packed {
    logic csrrw;
    logic csrrs;
    logic csrrc;
    logic csrrwi;
    logic csrrsi;
    logic csrrci;
  } csr_op_type;

  typedef struct packed {
    logic muls;
    logic mulh;
    logic mulhsu;
    logic mulhu;
  } mul_op_type;

  typedef struct packed {
    logic divs;
    logic divu;
    logic rem;
    logic remu;
  } div_op_type;

  localparam alu_op_type init_alu_op = '0;
  localparam csr_op_type init_csr_op = '0;
  localparam mul_op_type init_mul_op = '0;
  localparam div_op_type init_div_op = '0;

  typedef struct packed {
    instr_word_u     instr;
    logic [1:0]      mode;
    logic [XLEN-1:0] mcounteren;
  } lane_in_type;

  typedef struct packed {
    logic [XLEN-1:0] imm;
    logic [4:0]      waddr;
    logic [4:0]      raddr1;
    logic [4:0]      raddr2;
    logic            wren;
    logic            rden1;
    logic            rden2;
    logic            cwren;
    logic            crden;
    logic            lui;
    logic            nop;
    logic            csrreg;
    logic            division;
    logic            mult;
    alu_op_type      alu_op;
    csr_op_type      csr_op;
    mul_op_type      mul_op;
    div_op_type      div_op;
    logic            ecall;
    logic            ebreak;
    logic            mret;
    logic            fence;
    logic            wfi;
    logic            valid;
  } postdecoder_out_type;

  typedef struct packed {
    postdecoder_out_type decoded;
    logic                dep; // Reads a register written by an earlier lane.
  } issue_slot_type;

endpackage

// File: logic/fetch_unpacker.sv
module fetch_unpacker
  import decode_pkg::*;
(
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       fetch_valid,
  input  logic [LANES-1:0][XLEN-1:0] fetch_packet,
  input  logic [1:0]                 mode,
  input  logic [XLEN-1:0]            mcounteren,
  output lane_in_type [LANES-1:0]    lane_in,
  output logic                       packet_valid
);

  logic [LANES-1:0][XLEN-1:0] packet_q;
  logic [1:0]                 mode_q;
  logic [XLEN-1:0]            mcounteren_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      packet_valid <= 1'b0;
    end else begin
      packet_valid <= fetch_valid;
    end
  end

  // Privilege context is sampled with the packet so that all lanes see the same one.
  always_ff @(posedge clk) begin
    if (fetch_valid) begin
      packet_q     <= fetch_packet;
      mode_q       <= mode;
      mcounteren_q <= mcounteren;
    end
  end

  always_comb begin
    for (int k = 0; k < LANES; k++) begin
      lane_in[k].instr      = packet_q[k];
      lane_in[k].mode       = mode_q;
      lane_in[k].mcounteren = mcounteren_q;
    end
  end

  // ####################################################################
  // Checks
  // ####################################################################

  packet_valid_known: assert property (
    @(posedge clk) disable iff (!arst_n)
    !$isunknown(packet_valid)
  );

endmodule

// File: logic/postdecoder.sv
module postdecoder
  import decode_pkg::*;
(
  input  lane_in_type         postdecoder_in,
  output postdecoder_out_type postdecoder_out
);

  logic [XLEN-1:0]     bits;
  r_view_type          r;
  sys_view_type        s;
  logic [XLEN-1:0]     imm_i;
  logic [XLEN-1:0]     imm_u;
  logic [XLEN-1:0]     imm_c;
  logic                rd_nonzero;
  logic                rs1_nonzero;
  logic                counter_csr;
  postdecoder_out_type dec;

  assign bits = postdecoder_in.instr;
  assign r    = postdecoder_in.instr.r_view;
  assign s    = postdecoder_in.instr.sys_view;

  assign imm_i = {{(XLEN-12){bits[31]}}, bits[31:20]};
  assign imm_u = {bits[31:12], 12'h000};
  assign imm_c = {{(XLEN-5){1'b0}}, s.src}; // Zero-extended zimm.

  assign rd_nonzero  = |r.rd;
  assign rs1_nonzero = |r.rs1;
  assign counter_csr = s.csr[11:5] == csr_counter_page;

  always_comb begin
    dec.imm      = '0;
    dec.waddr    = r.rd;
    dec.raddr1   = r.rs1;
    dec.raddr2   = r.rs2;
    dec.wren     = 1'b0;
    dec.rden1    = 1'b0;
    dec.rden2    = 1'b0;
    dec.cwren    = 1'b0;
    dec.crden    = 1'b0;
    dec.lui      = 1'b0;
    dec.nop      = 1'b0;
    dec.division = 1'b0;
    dec.mult     = 1'b0;
    dec.alu_op   = init_alu_op;
    dec.csr_op   = init_csr_op;
    dec.mul_op   = init_mul_op;
    dec.div_op   = init_div_op;
    dec.ecall    = 1'b0;
    dec.ebreak   = 1'b0;
    dec.mret     = 1'b0;
    dec.fence    = 1'b0;
    dec.wfi      = 1'b0;
    dec.valid    = 1'b1;

    case (r.opcode)
      opcode_lui: begin
        dec.imm  = imm_u;
        dec.wren = rd_nonzero;
        dec.lui  = 1'b1;
      end
      opcode_immediate: begin
        dec.imm   = imm_i;
        dec.wren  = rd_nonzero;
        dec.rden1 = 1'b1;
        case (r.funct3)
          funct_add:  dec.alu_op.alu_add = 1'b1;
          funct_slt:  dec.alu_op.alu_slt = 1'b1;
          funct_sltu: dec.alu_op.alu_sltu = 1'b1;
          funct_xor:  dec.alu_op.alu_xor = 1'b1;
          funct_or:   dec.alu_op.alu_or = 1'b1;
          funct_and:  dec.alu_op.alu_and = 1'b1;
          funct_sll: begin
            dec.alu_op.alu_sll = 1'b1;
            dec.valid = r.funct7 == funct7_base; // Shift amount is 5 bits on RV32.
          end
          funct_srl: begin
            dec.alu_op.alu_srl = r.funct7 == funct7_base;
            dec.alu_op.alu_sra = r.funct7 == funct7_alt;
            dec.valid = dec.alu_op.alu_srl | dec.alu_op.alu_sra;
          end
        endcase
      end
      opcode_register: begin
        dec.wren  = rd_nonzero;
        dec.rden1 = 1'b1;
        dec.rden2 = 1'b1;
        if (r.funct7 == funct7_muldiv) begin
          dec.mult     = ~r.funct3[2]; // Bit 2 of funct3 splits multiply from divide.
          dec.division = r.funct3[2];
          case (r.funct3)
            funct_mul:    dec.mul_op.muls = 1'b1;
            funct_mulh:   dec.mul_op.mulh = 1'b1;
            funct_mulhsu: dec.mul_op.mulhsu = 1'b1;
            funct_mulhu:  dec.mul_op.mulhu = 1'b1;
            funct_div:    dec.div_op.divs = 1'b1;
            funct_divu:   dec.div_op.divu = 1'b1;
            funct_rem:    dec.div_op.rem = 1'b1;
            funct_remu:   dec.div_op.remu = 1'b1;
          endcase
        end else begin
          case (r.funct3)
            funct_add: begin
              dec.alu_op.alu_add = r.funct7 == funct7_base;
              dec.alu_op.alu_sub = r.funct7 == funct7_alt;
            end
            funct_srl: begin
              dec.alu_op.alu_srl = r.funct7 == funct7_base;
              dec.alu_op.alu_sra = r.funct7 == funct7_alt;
            end
            funct_sll:  dec.alu_op.alu_sll = 1'b1;
            funct_slt:  dec.alu_op.alu_slt = 1'b1;
            funct_sltu: dec.alu_op.alu_sltu = 1'b1;
            funct_xor:  dec.alu_op.alu_xor = 1'b1;
            funct_or:   dec.alu_op.alu_or = 1'b1;
            funct_and:  dec.alu_op.alu_and = 1'b1;
          endcase
          dec.valid = (r.funct7 == funct7_base) ||
                      (r.funct7 == funct7_alt && (r.funct3 == funct_add ||
                                                  r.funct3 == funct_srl));
        end
      end
      opcode_system: begin
        dec.imm = imm_c;
        case (s.funct3)
          funct_priv: begin
            case (s.csr)
              csr_ecall:  dec.ecall = 1'b1;
              csr_ebreak: dec.ebreak = 1'b1;
              csr_mret:   dec.mret = 1'b1;
              csr_wfi:    dec.wfi = 1'b1;
              default:    dec.valid = 1'b0;
            endcase
          end
          funct_csrrw: begin
            dec.rden1 = 1'b1;
            dec.cwren = 1'b1;
            dec.crden = rd_nonzero; // No CSR read side effects for rd = x0.
            dec.csr_op.csrrw = 1'b1;
          end
          funct_csrrs: begin
            dec.rden1 = 1'b1;
            dec.cwren = rs1_nonzero;
            dec.crden = 1'b1;
            dec.csr_op.csrrs = 1'b1;
          end
          funct_csrrc: begin
            dec.rden1 = 1'b1;
            dec.cwren = rs1_nonzero;
            dec.crden = 1'b1;
            dec.csr_op.csrrc = 1'b1;
          end
          funct_csrrwi: begin
            dec.cwren = 1'b1;
            dec.crden = rd_nonzero;
            dec.csr_op.csrrwi = 1'b1;
          end
          funct_csrrsi: begin
            dec.cwren = |s.src;
            dec.crden = 1'b1;
            dec.csr_op.csrrsi = 1'b1;
          end
          funct_csrrci: begin
            dec.cwren = |s.src;
            dec.crden = 1'b1;
            dec.csr_op.csrrci = 1'b1;
          end
          default: dec.valid = 1'b0;
        endcase
        dec.wren = rd_nonzero && s.funct3 != funct_priv;
      end
      opcode_fence: begin
        dec.fence = r.funct3 == funct_fence || r.funct3 == funct_fence_i;
        dec.valid = dec.fence;
      end
      default: dec.valid = 1'b0;
    endcase

    dec.csrreg = |dec.csr_op;

    if (bits == nop_instr) begin
      dec.alu_op.alu_add = 1'b0;
      dec.nop = 1'b1;
    end

    // ##################################################################
    // CSR privilege check
    // ##################################################################
    if (dec.csrreg) begin
      if (postdecoder_in.mode < s.csr[9:8]) begin
        dec.valid = 1'b0;
      end
      if (counter_csr && postdecoder_in.mode != mode_machine &&
          !postdecoder_in.mcounteren[s.csr[4:0]]) begin
        dec.valid = 1'b0; // Counter not delegated below machine mode.
      end
    end
  end

  assign postdecoder_out = dec;

endmodule

// File: logic/issue_collector.sv
module issue_collector
  import decode_pkg::*;
(
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              packet_valid,
  input  postdecoder_out_type [LANES-1:0]   decoded,
  output logic                              issue_valid,
  output issue_slot_type [LANES-1:0]        issue_slots
);

  logic [LANES-1:0] dep;

  // Lane 0 has no earlier lane, so its flag stays clear.
  always_comb begin
    dep = '0;
    for (int k = 1; k < LANES; k++) begin
      for (int j = 0; j < k; j++) begin
        if (decoded[j].wren &&
            ((decoded[k].rden1 && decoded[k].raddr1 == decoded[j].waddr) ||
             (decoded[k].rden2 && decoded[k].raddr2 == decoded[j].waddr))) begin
          dep[k] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      issue_valid <= 1'b0;
      issue_slots <= '0;
    end else begin
      issue_valid <= packet_valid;
      if (packet_valid) begin
        for (int k = 0; k < LANES; k++) begin
          issue_slots[k].decoded <= decoded[k];
          issue_slots[k].dep     <= dep[k];
        end
      end
    end
  end

  // ####################################################################
  // Checks on the issued slots
  // ####################################################################

  for (genvar k = 0; k < LANES; k++) begin : g_slot_checks
    op_flags_onehot: assert property (
      @(posedge clk) disable iff (!arst_n)
      issue_valid |-> $onehot0(issue_slots[k].decoded.alu_op) &&
                      $onehot0(issue_slots[k].decoded.csr_op) &&
                      $onehot0(issue_slots[k].decoded.mul_op) &&
                      $onehot0(issue_slots[k].decoded.div_op)
    );

    unit_select_exclusive: assert property (
      @(posedge clk) disable iff (!arst_n)
      issue_valid |-> $onehot0({issue_slots[k].decoded.mult,
                                issue_slots[k].decoded.division,
                                issue_slots[k].decoded.csrreg})
    );
  end

endmodule

// File: logic/decode_stage.sv
module decode_stage
  import decode_pkg::*;
(
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       fetch_valid,
  input  logic [LANES-1:0][XLEN-1:0] fetch_packet,
  input  logic [1:0]                 mode,
  input  logic [XLEN-1:0]            mcounteren,
  output logic                       issue_valid,
  output issue_slot_type [LANES-1:0] issue_slots
);

  lane_in_type [LANES-1:0]         lane_in;
  logic                            packet_valid;
  postdecoder_out_type [LANES-1:0] decoded;

  fetch_unpacker fetch_unpacker_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .fetch_valid  (fetch_valid),
    .fetch_packet (fetch_packet),
    .mode         (mode),
    .mcounteren   (mcounteren),
    .lane_in      (lane_in),
    .packet_valid (packet_valid)
  );

  for (genvar k = 0; k < LANES; k++) begin : g_lane
    postdecoder postdecoder_inst (
      .postdecoder_in  (lane_in[k]),
      .postdecoder_out (decoded[k])
    );
  end

  issue_collector issue_collector_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .packet_valid (packet_valid),
    .decoded      (decoded),
    .issue_valid  (issue_valid),
    .issue_slots  (issue_slots)
  );

endmodule

// File: test/decode_vectors.svh
`ifndef decode_vectors_svh
`define decode_vectors_svh

// Each row holds instr0, instr1, mode, mcounteren and the expected results of lanes 0 and 1.
// A lane holds en {valid, wren, rden1, rden2, cwren, crden}, unit {lui, mult, division, csrreg},
//   imm, alu_op, mul_op, div_op, csr_op, sys {ecall, ebreak, mret, fence, wfi}, nop, dep.
// Flag fields keep the bit order of the decoded structs, first flag in the top bit.

typedef struct packed {
  logic [5:0]  en;
  logic [3:0]  unit;
  logic [31:0] imm;
  logic [9:0]  alu_op;
  logic [3:0]  mul_op;
  logic [3:0]  div_op;
  logic [5:0]  csr_op;
  logic [4:0]  sys;
  logic        nop;
  logic        dep;
} lane_expect_type;

typedef struct packed {
  logic [31:0]     instr0;
  logic [31:0]     instr1;
  logic [1:0]      mode;
  logic [31:0]     mcounteren;
  lane_expect_type lane0;
  lane_expect_type lane1;
} vector_type;

localparam int num_vectors = 17;

vector_type vectors [num_vectors] = '{
  '{32'hFF01_0093, 32'h0000_81B7, 2'b11, 32'h0, // addi x1,x2,-16 | lui x3,0x8
    '{6'b111000, 4'h0, 32'hFFFF_FFF0, 10'h200, 4'h0, 4'h0, 6'h00, 5'h00, 1'b0, 1'b0},
    '{6'b110000, 4'h8, 32'h0000_8000, 10'h000, 4'h0, 4'h0, 6'h00, 5'h00, 1'b0, 1'b0}},
  '{32'h4073_02B3, 32'h4092_D433, 2'b11, 32'h0, // sub x5,x6,x7 | sra x8,x5,x9
    '{6'b111100, 4'h0, 32'h0000_0000, 10'h100, 4'h0, 4'h0, 6'h00, 5'h00, 1'b0, 1'b0},
    '{6'b111100, 4'h0, 32'h0000_0000, 10'h020, 4'h0, 4'h0, 6'h00, 5'h00, 1'b0, 1'b1}},
  '{32'h4035_D513, 32'h0055_0013, 2'b11, 32'h0, // srai x10,x11,3 | addi x0,x10,5
    '{6'b111000, 4'h0, 32'h0000_0403, 10'h020, 4'h0, 4'h0, 6'h00, 5'h00, 1'b0, 1'b0},
    '{6'b101000, 4'h0, 32'h0000_0005, 10'h200, 4'h0, 4'h0, 6'h00, 5'h00, 1'b0, 1'b1}},
  '{32'h0000_0013, 32'h0000_00B3, 2'b11, 32'h0, // nop | add x1,x0,x0
    '{6'b101000, 4'h0, 32'h0000_0000, 10'h000, 4'h0, 4'h0, 6'h00, 5'h00, 1'b1, 1'b0},
    '{6'b111100, 4'h0, 32'h0000_0000, 10'h200, 4'h0, 4'h0, 6'h00, 5'h00, 1'b0, 1'b0}},
  '{32'h0231_00B3, 32'h0262_9233, 2'b11, 32'h0, // mul x1,x2,x3 | mulh x4,x5,x6
    '{6'b111100, 4'h4, 32'h0000_0000, 10'h000, 4'h8, 4'h0, 6'h00, 5'h00, 1'b0, 1'b0},
    '{6'b111100, 4'h4, 32'h0000_0000, 10'h000, 4'h4, 4'h0, 6'h00, 5'h00, 1'b0, 1'b0}},
  '{32'h0294_23B3, 32'h02B3_B533, 2'b11, 32'h0, // mulhsu x7,x8,x9 | mulhu x10,x7,x11
    '{6'b111100, 4'h4, 32'h0000_0000, 10'h000, 4'h2, 4'h0, 6'h00, 5'h00, 1'b0, 1'b0},
    '{6'b111100, 4'h4, 32'h0000_0000, 10'h000, 4'h1, 4'h0, 6'h00, 5'h00, 1'b0, 1'b1}},
  '{32'h02E6_C633, 32'h02C8_57B3, 2'b11, 32'h0, // div x12,x13,x14 | divu x15,x16,x12
    '{6'b111100, 4'h2, 32'h0000_0000, 10'h000, 4'h0, 4'h8, 6'h00, 5'h00, 1'b0, 1'b0},
    '{6'b111100, 4'h2, 32'h0000_0000, 10'h000, 4'h0, 4'h4, 6'h00, 5'h00, 1'b0, 1'b1}},
  '{32'h0339_68B3, 32'h036A_FA33, 2'b11, 32'h0, // rem x17,x18,x19 | remu x20,x21,x22
    '{6'b111100, 4'h2, 32'h0000_0000, 10'h000, 4'h0, 4'h2, 6'h00, 5'h00, 1'b0, 1'b0},
    '{6'b111100, 4'h2, 32'h0000_0000, 10'h000, 4'h0, 4'h1, 6'h00, 5'h00, 1'b0, 1'b0}},
  '{32'h3400_22F3, 32'h3403_1073, 2'b11, 32'h0, // csrrs x5,mscratch,x0 | csrrw x0,mscratch,x6
    '{6'b111001, 4'h1, 32'h0000_0000, 10'h000, 4'h0, 4'h0, 6'h10, 5'h00, 1'b0, 1'b0},
    '{6'b101010, 4'h1, 32'h0000_0006, 10'h000, 4'h0, 4'h0, 6'h20, 5'h00, 1'b0, 1'b0}},
  '{32'h3400_63F3, 32'h340A_F473, 2'b11, 32'h0, // csrrsi x7,mscratch,0 | csrrci x8,mscratch,21
    '{6'b110001, 4'h1, 32'h0000_0000, 10'h000, 4'h0, 4'h0, 6'h02, 5'h00, 1'b0, 1'b0},
    '{6'b110011, 4'h1, 32'h0000_0015, 10'h000, 4'h0, 4'h0, 6'h01, 5'h00, 1'b0, 1'b0}},
  '{32'h3000_20F3, 32'hC000_2173, 2'b00, 32'h0, // User mode csrrs x1,mstatus | csrrs x2,cycle
    '{6'b011001, 4'h1, 32'h0000_0000, 10'h000, 4'h0, 4'h0, 6'h10, 5'h00, 1'b0, 1'b0},
    '{6'b011001, 4'h1, 32'h0000_0000, 10'h000, 4'h0, 4'h0, 6'h10, 5'h00, 1'b0, 1'b0}},
  '{32'hC020_21F3, 32'hC010_2273, 2'b00, 32'h4, // User mode csrrs x3,instret | csrrs x4,time
    '{6'b111001, 4'h1, 32'h0000_0000, 10'h000, 4'h0, 4'h0, 6'h10, 5'h00, 1'b0, 1'b0},
    '{6'b011001, 4'h1, 32'h0000_0000, 10'h000, 4'h0, 4'h0, 6'h10, 5'h00, 1'b0, 1'b0}},
  '{32'hC000_22F3, 32'h1402_B373, 2'b11, 32'h0, // csrrs x5,cycle | csrrc x6,sscratch,x5
    '{6'b111001, 4'h1, 32'h0000_0000, 10'h000, 4'h0, 4'h0, 6'h10, 5'h00, 1'b0, 1'b0},
    '{6'b111011, 4'h1, 32'h0000_0005, 10'h000, 4'h0, 4'h0, 6'h08, 5'h00, 1'b0, 1'b1}},
  '{32'h0000_0073, 32'h0010_0073, 2'b11, 32'h0, // ecall | ebreak
    '{6'b100000, 4'h0, 32'h0000_0000, 10'h000, 4'h0, 4'h0, 6'h00, 5'h10, 1'b0, 1'b0},
    '{6'b100000, 4'h0, 32'h0000_0000, 10'h000, 4'h0, 4'h0, 6'h00, 5'h08, 1'b0, 1'b0}},
  '{32'h3020_0073, 32'h1050_0073, 2'b11, 32'h0, // mret | wfi
    '{6'b100000, 4'h0, 32'h0000_0000, 10'h000, 4'h0, 4'h0, 6'h00, 5'h04, 1'b0, 1'b0},
    '{6'b100000, 4'h0, 32'h0000_0000, 10'h000, 4'h0, 4'h0, 6'h00, 5'h01, 1'b0, 1'b0}},
  '{32'h0FF0_000F, 32'h0211_1093, 2'b11, 32'h0, // fence | slli x1,x2 with bit 25 set
    '{6'b100000, 4'h0, 32'h0000_0000, 10'h000, 4'h0, 4'h0, 6'h00, 5'h02, 1'b0, 1'b0},
    '{6'b011000, 4'h0, 32'h0000_0021, 10'h080, 4'h0, 4'h0, 6'h00, 5'h00, 1'b0, 1'b0}},
  '{32'h0020_A023, 32'h0020_0073, 2'b11, 32'h0, // sw x2,0(x1) | SYSTEM funct12 0x002
    '{6'b000000, 4'h0, 32'h0000_0000, 10'h000, 4'h0, 4'h0, 6'h00, 5'h00, 1'b0, 1'b0},
    '{6'b000000, 4'h0, 32'h0000_0000, 10'h000, 4'h0, 4'h0, 6'h00, 5'h00, 1'b0, 1'b0}}
};

`endif

// File: test/decode_stage_tb.sv
module decode_stage_tb
  import decode_pkg::*;
();

  localparam int issue_timeout = 10;
  localparam int first_burst_row = 1;

  logic                       clk;
  logic                       arst_n;
  logic                       fetch_valid;
  logic [LANES-1:0][XLEN-1:0] fetch_packet;
  logic [1:0]                 mode;
  logic [XLEN-1:0]            mcounteren;
  logic                       issue_valid;
  issue_slot_type [LANES-1:0] issue_slots;

  `include "decode_vectors.svh"

  decode_stage decode_stage_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .fetch_valid  (fetch_valid),
    .fetch_packet (fetch_packet),
    .mode         (mode),
    .mcounteren   (mcounteren),
    .issue_valid  (issue_valid),
    .issue_slots  (issue_slots)
  );

  always #50 clk = ~clk;

  // ####################################################################
  // Reporting and checks
  // ####################################################################

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] want);
    assert (got === want) else
      abort_run($sformatf("** Error at %0t: %s is %0h, expected %0h", $time, name, got, want));
  endtask

  task automatic check_lane(input int k, input lane_expect_type want);
    issue_slot_type slot;
    string          p;
    slot = issue_slots[k];
    p = $sformatf("lane %0d ", k);
    check_field({p, "valid"}, slot.decoded.valid, want.en[5]);
    check_field({p, "wren"}, slot.decoded.wren, want.en[4]);
    check_field({p, "rden1"}, slot.decoded.rden1, want.en[3]);
    check_field({p, "rden2"}, slot.decoded.rden2, want.en[2]);
    check_field({p, "cwren"}, slot.decoded.cwren, want.en[1]);
    check_field({p, "crden"}, slot.decoded.crden, want.en[0]);
    check_field({p, "lui/mult/division/csrreg"}, {slot.decoded.lui, slot.decoded.mult,
                slot.decoded.division, slot.decoded.csrreg}, want.unit);
    check_field({p, "imm"}, slot.decoded.imm, want.imm);
    check_field({p, "alu_op"}, slot.decoded.alu_op, want.alu_op);
    check_field({p, "mul_op"}, slot.decoded.mul_op, want.mul_op);
    check_field({p, "div_op"}, slot.decoded.div_op, want.div_op);
    check_field({p, "csr_op"}, slot.decoded.csr_op, want.csr_op);
    check_field({p, "system flags"}, {slot.decoded.ecall, slot.decoded.ebreak,
                slot.decoded.mret, slot.decoded.fence, slot.decoded.wfi}, want.sys);
    check_field({p, "nop"}, slot.decoded.nop, want.nop);
    check_field({p, "dep"}, slot.dep, want.dep);
  endtask

  task automatic check_row(input int idx);
    check_lane(0, vectors[idx].lane0);
    check_lane(1, vectors[idx].lane1);
  endtask

  // ####################################################################
  // Stimulus
  // ####################################################################

  task automatic drive_row(input int idx);
    fetch_packet[0] = vectors[idx].instr0;
    fetch_packet[1] = vectors[idx].instr1;
    mode            = vectors[idx].mode;
    mcounteren      = vectors[idx].mcounteren;
    fetch_valid     = 1'b1;
  endtask

  task automatic wait_issue();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!issue_valid && cycles < issue_timeout);
    if (!issue_valid) begin
      abort_run("issue_valid never arrived within 10 cycles of a fetch strobe");
    end
  endtask

  initial begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    fetch_valid  = 1'b0;
    fetch_packet = '0;
    mode         = 2'b11;
    mcounteren   = '0;
    void'($urandom(32'h31ee));

    repeat (5) @(negedge clk);
    arst_n = 1'b1;
    check_field("issue_valid after reset", issue_valid, 1'b0);
    assert (issue_slots === '0) else
      abort_run($sformatf("** Error at %0t: issue_slots not cleared by reset", $time));

    for (int i = 0; i < num_vectors; i++) begin
      repeat ($urandom_range(2, 0)) @(negedge clk); // Random gap between packets.
      @(negedge clk);
      drive_row(i);
      @(negedge clk);
      fetch_valid = 1'b0;
      wait_issue();
      check_row(i);
    end

    // Three packets on consecutive cycles must come out on consecutive cycles.
    fork
      begin
        for (int n = 0; n < 3; n++) begin
          @(negedge clk);
          drive_row(first_burst_row + n);
        end
        @(negedge clk);
        fetch_valid = 1'b0;
      end
      begin
        wait_issue();
        check_row(first_burst_row);
        for (int n = 1; n < 3; n++) begin
          @(negedge clk);
          check_field("issue_valid in burst", issue_valid, 1'b1);
          check_row(first_burst_row + n);
        end
        @(negedge clk);
        check_field("issue_valid after burst", issue_valid, 1'b0);
      end
    join

    $display("Everything OK");
    $finish;
  end

endmodule

// File: project.f
+incdir+test
logic/decode_pkg.sv
logic/fetch_unpacker.sv
logic/postdecoder.sv
logic/issue_collector.sv
logic/decode_stage.sv
test/decode_stage_tb.sv
